/* compile.f */
hdl/global_buffer_pkg.sv
hdl/glb_west_edge.sv
hdl/glb_tile.sv
hdl/glb_east_edge.sv
hdl/global_buffer.sv
testbench/global_buffer_props.sv
testbench/global_buffer_tb.sv

/* hdl/glb_east_edge.sv */
//////////////////////////////////////////////////
// turnaround at the east end of the chain. one
// register stage, cleared to an empty packet
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module glb_east_edge
    import global_buffer_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    input  packet_t pkt_w2e_in,
    output packet_t pkt_e2w_out
);

    // every packet goes back west unchanged
    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_e2w_out <= PKT_EMPTY;
        end else begin
            pkt_e2w_out <= pkt_w2e_in;
        end
    end

endmodule

`default_nettype wire

/* hdl/glb_tile.sv */
//////////////////////////////////////////////////
// one buffer tile: bank, two packet stages, config
// registers and a stream engine. host bank access
// while this tile streams is not supported. no
// back-pressure on the stream output
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module glb_tile
    import global_buffer_pkg::*;
#(
    parameter tile_sel_t TILE_ID = 2'd0
) (
    input  logic       clk,
    input  logic       rst,

    input  packet_t    pkt_w2e_in,
    output packet_t    pkt_w2e_out,
    input  packet_t    pkt_e2w_in,
    output packet_t    pkt_e2w_out,

    input  tile_mask_t strm_start_in,
    output tile_mask_t strm_start_out,
    input  tile_mask_t interrupt_in,
    output tile_mask_t interrupt_out,

    output cgra_data_t strm_data,
    output logic       strm_data_valid
);

    bank_data_t  bank_mem [BANK_DEPTH];

    cfg_data_t   cfg_start;
    cfg_data_t   cfg_count;
    cfg_data_t   cfg_rd_val;

    logic        mem_wr;
    logic        mem_rd;
    logic        cfg_wr;
    logic        cfg_rd;
    tile_sel_t   mem_tile;
    tile_sel_t   cfg_tile;
    bank_addr_t  pkt_word;
    logic [CFG_REG_WIDTH-1:0] pkt_reg;
    packet_t     pkt_w2e_next;

    strm_state_e strm_state;
    bank_addr_t  strm_ptr;
    cfg_data_t   strm_rem;
    logic        strm_done;
    logic        strm_busy;
    bank_data_t  strm_word;

    // address decode of the passing packet
    assign mem_tile = pkt_w2e_in.addr[BANK_ADDR_WIDTH +: TILE_SEL_WIDTH];
    assign cfg_tile = pkt_w2e_in.addr[CFG_REG_WIDTH +: TILE_SEL_WIDTH];
    assign pkt_word = pkt_w2e_in.addr[BANK_ADDR_WIDTH-1:0];
    assign pkt_reg  = pkt_w2e_in.addr[CFG_REG_WIDTH-1:0];

    assign mem_wr = (pkt_w2e_in.op == PKT_MEM_WR) && (mem_tile == TILE_ID);
    assign mem_rd = (pkt_w2e_in.op == PKT_MEM_RD) && (mem_tile == TILE_ID);
    assign cfg_wr = (pkt_w2e_in.op == PKT_CFG_WR) && (cfg_tile == TILE_ID);
    assign cfg_rd = (pkt_w2e_in.op == PKT_CFG_RD) && (cfg_tile == TILE_ID);

    // byte-strobed bank write
    always_ff @(posedge clk) begin
        if (mem_wr) begin
            for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
                if (pkt_w2e_in.strb[b]) begin
                    bank_mem[pkt_word][b*8 +: 8] <= pkt_w2e_in.data[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_start <= '0;
            cfg_count <= '0;
        end else if (cfg_wr) begin
            if (pkt_reg == CFG_REG_START) begin
                cfg_start <= pkt_w2e_in.data;
            end
            if (pkt_reg == CFG_REG_COUNT) begin
                cfg_count <= pkt_w2e_in.data;
            end
        end
    end

    always_comb begin
        case (pkt_reg)
            CFG_REG_START:  cfg_rd_val = cfg_start;
            CFG_REG_COUNT:  cfg_rd_val = cfg_count;
            CFG_REG_STATUS: cfg_rd_val = cfg_data_t'(strm_busy);
            default:        cfg_rd_val = '0;
        endcase
    end

    // read hits replace the payload, old bank contents
    always_comb begin
        pkt_w2e_next = pkt_w2e_in;
        if (mem_rd) begin
            pkt_w2e_next.data = bank_mem[pkt_word];
        end else if (cfg_rd) begin
            pkt_w2e_next.data = cfg_rd_val;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_w2e_out    <= PKT_EMPTY;
            pkt_e2w_out    <= PKT_EMPTY;
            strm_start_out <= '0;
        end else begin
            pkt_w2e_out    <= pkt_w2e_next;
            pkt_e2w_out    <= pkt_e2w_in;
            strm_start_out <= strm_start_in;
        end
    end

    // stream engine, started by the registered pulse bit
    always_ff @(posedge clk) begin
        if (rst) begin
            strm_state <= STRM_IDLE;
            strm_ptr   <= '0;
            strm_rem   <= '0;
            strm_done  <= 1'b0;
        end else begin
            strm_done <= 1'b0;
            case (strm_state)
                STRM_IDLE: begin
                    if (strm_start_out[TILE_ID]) begin
                        strm_ptr <= cfg_start[BANK_ADDR_WIDTH-1:0];
                        strm_rem <= cfg_count;
                        if (cfg_count == '0) begin
                            strm_done <= 1'b1;
                        end else begin
                            strm_state <= STRM_LOW;
                        end
                    end
                end
                STRM_LOW: begin
                    strm_state <= STRM_HIGH;
                end
                STRM_HIGH: begin
                    if (strm_rem == cfg_data_t'(1)) begin
                        strm_state <= STRM_IDLE;
                        strm_done  <= 1'b1;
                    end else begin
                        strm_state <= STRM_LOW;
                    end
                    strm_rem <= strm_rem - 1'b1;
                    strm_ptr <= strm_ptr + 1'b1;
                end
                default: strm_state <= STRM_IDLE;
            endcase
        end
    end

    assign strm_busy       = (strm_state != STRM_IDLE);
    assign strm_word       = bank_mem[strm_ptr];
    assign strm_data_valid = strm_busy;
    // low half first
    assign strm_data = (strm_state == STRM_HIGH) ? strm_word[BANK_DATA_WIDTH-1 -: CGRA_DATA_WIDTH]
                                                 : strm_word[CGRA_DATA_WIDTH-1:0];

    assign interrupt_out = interrupt_in | (tile_mask_t'(strm_done) << TILE_ID);

endmodule

`default_nettype wire

/* hdl/glb_west_edge.sv */
//////////////////////////////////////////////////
// host side of the chain. one request per cycle;
// proc and cfg strobes must not overlap. write
// priority is proc write, proc read, cfg write,
// cfg read
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module glb_west_edge
    import global_buffer_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       proc_wr_en,
    input  bank_strb_t proc_wr_strb,
    input  glb_addr_t  proc_wr_addr,
    input  bank_data_t proc_wr_data,
    input  logic       proc_rd_en,
    input  glb_addr_t  proc_rd_addr,
    output bank_data_t proc_rd_data,
    output logic       proc_rd_data_valid,

    input  logic       cfg_wr_en,
    input  cfg_addr_t  cfg_wr_addr,
    input  cfg_data_t  cfg_wr_data,
    input  logic       cfg_rd_en,
    input  cfg_addr_t  cfg_rd_addr,
    output cfg_data_t  cfg_rd_data,
    output logic       cfg_rd_data_valid,

    input  packet_t    pkt_e2w_in,
    output packet_t    pkt_w2e_out
);

    packet_t req_pkt;

    // build the outgoing packet from whichever strobe is set
    always_comb begin
        req_pkt = PKT_EMPTY;
        if (proc_wr_en) begin
            req_pkt = '{op: PKT_MEM_WR, addr: proc_wr_addr, strb: proc_wr_strb,
                        data: proc_wr_data};
        end else if (proc_rd_en) begin
            req_pkt = '{op: PKT_MEM_RD, addr: proc_rd_addr, strb: '0, data: '0};
        end else if (cfg_wr_en) begin
            req_pkt = '{op: PKT_CFG_WR, addr: glb_addr_t'(cfg_wr_addr), strb: '1,
                        data: cfg_wr_data};
        end else if (cfg_rd_en) begin
            req_pkt = '{op: PKT_CFG_RD, addr: glb_addr_t'(cfg_rd_addr), strb: '0,
                        data: '0};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_w2e_out <= PKT_EMPTY;
        end else begin
            pkt_w2e_out <= req_pkt;
        end
    end

    // returning packets; write packets end here
    always_ff @(posedge clk) begin
        if (rst) begin
            proc_rd_data_valid <= 1'b0;
            cfg_rd_data_valid  <= 1'b0;
        end else begin
            proc_rd_data_valid <= (pkt_e2w_in.op == PKT_MEM_RD);
            cfg_rd_data_valid  <= (pkt_e2w_in.op == PKT_CFG_RD);
        end
    end

    always_ff @(posedge clk) begin
        if (pkt_e2w_in.op == PKT_MEM_RD) begin
            proc_rd_data <= pkt_e2w_in.data;
        end
        if (pkt_e2w_in.op == PKT_CFG_RD) begin
            cfg_rd_data <= pkt_e2w_in.data;
        end
    end

endmodule

`default_nettype wire

/* hdl/global_buffer.sv */
//////////////////////////////////////////////////
// global buffer top: west edge, four tiles, east
// edge. read latency is 10 cycles for every tile.
// proc and cfg strobes must not be set together
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module global_buffer
    import global_buffer_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // processor port
    input  logic       proc_wr_en,
    input  bank_strb_t proc_wr_strb,
    input  glb_addr_t  proc_wr_addr,
    input  bank_data_t proc_wr_data,
    input  logic       proc_rd_en,
    input  glb_addr_t  proc_rd_addr,
    output bank_data_t proc_rd_data,
    output logic       proc_rd_data_valid,

    // configuration port
    input  logic       cfg_wr_en,
    input  cfg_addr_t  cfg_wr_addr,
    input  cfg_data_t  cfg_wr_data,
    input  logic       cfg_rd_en,
    input  cfg_addr_t  cfg_rd_addr,
    output cfg_data_t  cfg_rd_data,
    output logic       cfg_rd_data_valid,

    // fabric side
    output cgra_data_t strm_data [NUM_GLB_TILES],
    output logic       strm_data_valid [NUM_GLB_TILES],
    input  tile_mask_t strm_start_pulse,
    output tile_mask_t interrupt_pulse
);

    // index i is the west side of tile i
    packet_t    pkt_w2e [NUM_GLB_TILES+1];
    packet_t    pkt_e2w [NUM_GLB_TILES+1];
    tile_mask_t strm_start [NUM_GLB_TILES+1];
    tile_mask_t irq [NUM_GLB_TILES+1];

    assign strm_start[0]       = strm_start_pulse;
    assign irq[NUM_GLB_TILES]  = '0;
    assign interrupt_pulse     = irq[0];

    glb_west_edge glb_west_edge_inst (
        .clk                (clk),
        .rst                (rst),
        .proc_wr_en         (proc_wr_en),
        .proc_wr_strb       (proc_wr_strb),
        .proc_wr_addr       (proc_wr_addr),
        .proc_wr_data       (proc_wr_data),
        .proc_rd_en         (proc_rd_en),
        .proc_rd_addr       (proc_rd_addr),
        .proc_rd_data       (proc_rd_data),
        .proc_rd_data_valid (proc_rd_data_valid),
        .cfg_wr_en          (cfg_wr_en),
        .cfg_wr_addr        (cfg_wr_addr),
        .cfg_wr_data        (cfg_wr_data),
        .cfg_rd_en          (cfg_rd_en),
        .cfg_rd_addr        (cfg_rd_addr),
        .cfg_rd_data        (cfg_rd_data),
        .cfg_rd_data_valid  (cfg_rd_data_valid),
        .pkt_e2w_in         (pkt_e2w[0]),
        .pkt_w2e_out        (pkt_w2e[0])
    );

    for (genvar i = 0; i < NUM_GLB_TILES; i++) begin : glb_tile_gen
        glb_tile #(
            .TILE_ID (tile_sel_t'(i))
        ) glb_tile_inst (
            .clk             (clk),
            .rst             (rst),
            .pkt_w2e_in      (pkt_w2e[i]),
            .pkt_w2e_out     (pkt_w2e[i+1]),
            .pkt_e2w_in      (pkt_e2w[i+1]),
            .pkt_e2w_out     (pkt_e2w[i]),
            .strm_start_in   (strm_start[i]),
            .strm_start_out  (strm_start[i+1]),
            .interrupt_in    (irq[i+1]),
            .interrupt_out   (irq[i]),
            .strm_data       (strm_data[i]),
            .strm_data_valid (strm_data_valid[i])
        );
    end

    glb_east_edge glb_east_edge_inst (
        .clk         (clk),
        .rst         (rst),
        .pkt_w2e_in  (pkt_w2e[NUM_GLB_TILES]),
        .pkt_e2w_out (pkt_e2w[NUM_GLB_TILES])
    );

endmodule

`default_nettype wire

/* hdl/global_buffer_pkg.sv */
//////////////////////////////////////////////////
// widths, types and packet format shared by the
// global buffer. host word address is {tile, word}
// and config address is {tile, register}
//////////////////////////////////////////////////
`default_nettype none

package global_buffer_pkg;

    localparam int NUM_GLB_TILES   = 4;
    localparam int BANK_DEPTH      = 64;

    localparam int TILE_SEL_WIDTH  = 2;
    localparam int BANK_ADDR_WIDTH = 6;
    localparam int GLB_ADDR_WIDTH  = TILE_SEL_WIDTH + BANK_ADDR_WIDTH;
    localparam int BANK_DATA_WIDTH = 32;
    localparam int BANK_STRB_WIDTH = BANK_DATA_WIDTH / 8;
    localparam int CFG_REG_WIDTH   = 2;
    localparam int CFG_ADDR_WIDTH  = TILE_SEL_WIDTH + CFG_REG_WIDTH;
    localparam int CFG_DATA_WIDTH  = 32;
    localparam int CGRA_DATA_WIDTH = 16;

    typedef logic [TILE_SEL_WIDTH-1:0]  tile_sel_t;
    typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;
    typedef logic [GLB_ADDR_WIDTH-1:0]  glb_addr_t;
    typedef logic [BANK_DATA_WIDTH-1:0] bank_data_t;
    typedef logic [BANK_STRB_WIDTH-1:0] bank_strb_t;
    typedef logic [CFG_ADDR_WIDTH-1:0]  cfg_addr_t;
    typedef logic [CFG_DATA_WIDTH-1:0]  cfg_data_t;
    typedef logic [CGRA_DATA_WIDTH-1:0] cgra_data_t;
    typedef logic [NUM_GLB_TILES-1:0]   tile_mask_t;

    // per-tile configuration register indices
    localparam logic [CFG_REG_WIDTH-1:0] CFG_REG_START  = 2'd0;
    localparam logic [CFG_REG_WIDTH-1:0] CFG_REG_COUNT  = 2'd1;
    localparam logic [CFG_REG_WIDTH-1:0] CFG_REG_STATUS = 2'd2;

    typedef enum logic [2:0] {
        PKT_NONE,
        PKT_MEM_WR,
        PKT_MEM_RD,
        PKT_CFG_WR,
        PKT_CFG_RD
    } packet_op_e;

    // cfg packets carry the config address in addr[3:0]
    typedef struct packed {
        packet_op_e op;
        glb_addr_t  addr;
        bank_strb_t strb;
        bank_data_t data;
    } packet_t;

    localparam packet_t PKT_EMPTY = '{op: PKT_NONE, addr: '0, strb: '0, data: '0};

    typedef enum logic [1:0] {
        STRM_IDLE,
        STRM_LOW,
        STRM_HIGH
    } strm_state_e;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build the global buffer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module global_buffer_tb -o global_buffer_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

sim_output=$(./obj_dir/global_buffer_tb)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* testbench/global_buffer_props.sv */
//////////////////////////////////////////////////
// assertions bound into global_buffer: no overlap
// of host strobes, no valid in reset and single
// cycle interrupt bits
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module global_buffer_props
    import global_buffer_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       proc_wr_en,
    input logic       proc_rd_en,
    input logic       cfg_wr_en,
    input logic       cfg_rd_en,
    input logic       proc_rd_data_valid,
    input logic       cfg_rd_data_valid,
    input logic       strm_data_valid [NUM_GLB_TILES],
    input tile_mask_t interrupt_pulse
);

    // failed assertions so far
    int fail_count = 0;

    // one host request per cycle
    assert property (@(posedge clk) disable iff (rst)
        !((proc_wr_en || proc_rd_en) && (cfg_wr_en || cfg_rd_en)))
        else begin
            fail_count++;
            $error("processor and configuration strobes active in the same cycle");
        end

    assert property (@(posedge clk) rst |=> !proc_rd_data_valid && !cfg_rd_data_valid)
        else begin
            fail_count++;
            $error("read valid high during reset");
        end

    for (genvar i = 0; i < NUM_GLB_TILES; i++) begin : tile_prop_gen
        assert property (@(posedge clk) rst |=> !strm_data_valid[i])
            else begin
                fail_count++;
                $error("stream valid of tile %0d high during reset", i);
            end
        assert property (@(posedge clk) disable iff (rst)
            interrupt_pulse[i] |=> !interrupt_pulse[i])
            else begin
                fail_count++;
                $error("interrupt bit %0d high for two cycles in a row", i);
            end
    end

endmodule

bind global_buffer global_buffer_props global_buffer_props_inst (
    .clk                (clk),
    .rst                (rst),
    .proc_wr_en         (proc_wr_en),
    .proc_rd_en         (proc_rd_en),
    .cfg_wr_en          (cfg_wr_en),
    .cfg_rd_en          (cfg_rd_en),
    .proc_rd_data_valid (proc_rd_data_valid),
    .cfg_rd_data_valid  (cfg_rd_data_valid),
    .strm_data_valid    (strm_data_valid),
    .interrupt_pulse    (interrupt_pulse)
);

`default_nettype wire

/* testbench/global_buffer_tb.sv */
//////////////////////////////////////////////////
// directed testbench for global_buffer. inputs
// change on the falling edge, outputs are checked
// there against a byte-level model. every bank
// word is written before it is read
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module global_buffer_tb
    import global_buffer_pkg::*;
();

    logic       clk;
    logic       rst;
    logic       proc_wr_en;
    logic       proc_rd_en;
    bank_strb_t proc_wr_strb;
    glb_addr_t  proc_wr_addr;
    glb_addr_t  proc_rd_addr;
    bank_data_t proc_wr_data;
    bank_data_t proc_rd_data;
    logic       proc_rd_data_valid;
    logic       cfg_wr_en;
    logic       cfg_rd_en;
    cfg_addr_t  cfg_wr_addr;
    cfg_addr_t  cfg_rd_addr;
    cfg_data_t  cfg_wr_data;
    cfg_data_t  cfg_rd_data;
    logic       cfg_rd_data_valid;
    cgra_data_t strm_data [NUM_GLB_TILES];
    logic       strm_data_valid [NUM_GLB_TILES];
    tile_mask_t strm_start_pulse;
    tile_mask_t interrupt_pulse;

    // model state; a stream window is the cycle range with valid high
    bank_data_t model_bank [NUM_GLB_TILES][BANK_DEPTH];
    cfg_data_t  model_start [NUM_GLB_TILES];
    cfg_data_t  model_count [NUM_GLB_TILES];
    int         strm_first [NUM_GLB_TILES];
    int         strm_last [NUM_GLB_TILES];
    cgra_data_t strm_exp_q [NUM_GLB_TILES][$];
    bank_data_t rd_exp_q [$];
    cfg_data_t  cfg_exp_q [$];
    int         rd_cyc_q [$];
    int         cfg_cyc_q [$];
    int         quiet_after = 0;
    int         cyc = 0;
    int         seed;
    int         mismatches = 0;
    int         failures = 0;
    string      test_name;

    global_buffer global_buffer_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check_bank_data(input bank_data_t exp, input bank_data_t act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s proc_rd_data expected %h actual %h", test_name, exp, act);
        end
    endtask

    task automatic check_cfg_data(input cfg_data_t exp, input cfg_data_t act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s cfg_rd_data expected %h actual %h", test_name, exp, act);
        end
    endtask

    task automatic check_strm_data(input int t, input cgra_data_t exp, input cgra_data_t act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s strm_data[%0d] expected %h actual %h", test_name, t, exp, act);
        end
    endtask

    task automatic check_irq(input tile_mask_t exp, input tile_mask_t act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s interrupt_pulse expected %b actual %b", test_name, exp, act);
        end
    endtask

    task automatic report_error(input string what);
        failures++;
        $display("ERROR %s: %s", test_name, what);
    endtask

    // response monitor that runs from reset on
    always @(negedge clk) begin
        tile_mask_t exp_irq;
        logic       exp_valid;
        for (int t = 0; t < NUM_GLB_TILES; t++) begin
            exp_irq[t] = (cyc == strm_last[t] + 1);
            exp_valid  = (cyc >= strm_first[t]) && (cyc <= strm_last[t]);
            if (strm_data_valid[t] !== exp_valid) begin
                report_error($sformatf("stream valid of tile %0d is %b where %b was due",
                                       t, strm_data_valid[t], exp_valid));
            end else if (exp_valid) begin
                check_strm_data(t, strm_exp_q[t].pop_front(), strm_data[t]);
            end
        end
        check_irq(exp_irq, interrupt_pulse);
        if (proc_rd_data_valid !== 1'b0) begin
            if (rd_exp_q.size() == 0) begin
                report_error("processor read response with no read outstanding");
            end else begin
                if (rd_cyc_q.pop_front() != cyc) begin
                    report_error("processor read response came at the wrong cycle");
                end
                check_bank_data(rd_exp_q.pop_front(), proc_rd_data);
            end
        end
        if (cfg_rd_data_valid !== 1'b0) begin
            if (cfg_exp_q.size() == 0) begin
                report_error("configuration read response with no read outstanding");
            end else begin
                if (cfg_cyc_q.pop_front() != cyc) begin
                    report_error("configuration read response came at the wrong cycle");
                end
                check_cfg_data(cfg_exp_q.pop_front(), cfg_rd_data);
            end
        end
    end

    task automatic drive_idle();
        proc_wr_en       = 1'b0;
        proc_rd_en       = 1'b0;
        cfg_wr_en        = 1'b0;
        cfg_rd_en        = 1'b0;
        strm_start_pulse = '0;
    endtask

    task automatic proc_write(input glb_addr_t addr, input bank_data_t data,
                              input bank_strb_t strb);
        tile_sel_t  t;
        bank_addr_t w;
        @(negedge clk);
        drive_idle();
        proc_wr_en   = 1'b1;
        proc_wr_addr = addr;
        proc_wr_data = data;
        proc_wr_strb = strb;
        t = tile_sel_t'(addr >> BANK_ADDR_WIDTH);
        w = bank_addr_t'(addr);
        for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
            if (strb[b]) begin
                model_bank[t][w][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endtask

    // response is due 2*tiles+2 cycles after the sampling edge
    task automatic proc_read(input glb_addr_t addr);
        @(negedge clk);
        drive_idle();
        proc_rd_en   = 1'b1;
        proc_rd_addr = addr;
        rd_exp_q.push_back(model_bank[tile_sel_t'(addr >> BANK_ADDR_WIDTH)][bank_addr_t'(addr)]);
        rd_cyc_q.push_back(cyc + 1 + 2 * NUM_GLB_TILES + 2);
    endtask

    task automatic cfg_write(input tile_sel_t t, input logic [1:0] reg_idx, input cfg_data_t data);
        @(negedge clk);
        drive_idle();
        cfg_wr_en   = 1'b1;
        cfg_wr_addr = {t, reg_idx};
        cfg_wr_data = data;
        if (reg_idx == CFG_REG_START) begin
            model_start[t] = data;
        end
        if (reg_idx == CFG_REG_COUNT) begin
            model_count[t] = data;
        end
    endtask

    task automatic cfg_read(input tile_sel_t t, input logic [1:0] reg_idx);
        cfg_data_t exp;
        int        hit;
        @(negedge clk);
        drive_idle();
        cfg_rd_en   = 1'b1;
        cfg_rd_addr = {t, reg_idx};
        // tile t sees the packet in the cycle after edge sample + t
        hit = cyc + 1 + int'(t);
        case (reg_idx)
            CFG_REG_START:  exp = model_start[t];
            CFG_REG_COUNT:  exp = model_count[t];
            CFG_REG_STATUS: exp = cfg_data_t'(hit >= strm_first[t] && hit <= strm_last[t]);
            default:        exp = '0;
        endcase
        cfg_exp_q.push_back(exp);
        cfg_cyc_q.push_back(cyc + 1 + 2 * NUM_GLB_TILES + 2);
    endtask

    task automatic start_streams(input tile_mask_t mask);
        bank_data_t word;
        int         s;
        @(negedge clk);
        drive_idle();
        strm_start_pulse = mask;
        s = cyc + 1;
        for (int t = 0; t < NUM_GLB_TILES; t++) begin
            if (mask[t]) begin
                // t+1 start stages before the FSM leaves idle
                strm_first[t] = s + t + 1;
                strm_last[t]  = s + t + 2 * int'(model_count[t]);
                if (strm_last[t] + 2 > quiet_after) begin
                    quiet_after = strm_last[t] + 2;
                end
                for (int w = 0; w < int'(model_count[t]); w++) begin
                    word = model_bank[t][bank_addr_t'(model_start[t] + w)];
                    strm_exp_q[t].push_back(word[15:0]);
                    strm_exp_q[t].push_back(word[31:16]);
                end
            end
        end
    endtask

    // until all responses and streams are done
    task automatic wait_quiet();
        @(negedge clk);
        drive_idle();
        while (cyc <= quiet_after || rd_exp_q.size() != 0 || cfg_exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic read_reset_values();
        test_name = "reset_values";
        for (int t = 0; t < NUM_GLB_TILES; t++) begin
            for (int r = 0; r < 3; r++) begin
                cfg_read(tile_sel_t'(t), 2'(r));
            end
        end
        wait_quiet();
    endtask

    task automatic write_then_read();
        test_name = "write_read";
        for (int a = 0; a < NUM_GLB_TILES * BANK_DEPTH; a++) begin
            proc_write(glb_addr_t'(a), bank_data_t'($random(seed)), '1);
        end
        for (int i = 0; i < 32; i++) begin
            proc_write(glb_addr_t'($random(seed)), bank_data_t'($random(seed)), '1);
        end
        for (int i = 0; i < 64; i++) begin
            proc_read(glb_addr_t'($random(seed)));
        end
        wait_quiet();
    endtask

    task automatic merge_partial_strobes();
        glb_addr_t addr;
        test_name = "partial_strobes";
        for (int i = 0; i < 16; i++) begin
            addr = glb_addr_t'($random(seed));
            proc_write(addr, bank_data_t'($random(seed)), bank_strb_t'($random(seed)));
            proc_read(addr);
        end
        wait_quiet();
    endtask

    task automatic read_back_cfg_regs();
        test_name = "cfg_regs";
        for (int t = 0; t < NUM_GLB_TILES; t++) begin
            cfg_write(tile_sel_t'(t), CFG_REG_START, cfg_data_t'($random(seed)));
            cfg_write(tile_sel_t'(t), CFG_REG_COUNT, cfg_data_t'($random(seed)));
        end
        for (int t = 0; t < NUM_GLB_TILES; t++) begin
            for (int r = 0; r < 3; r++) begin
                cfg_read(tile_sel_t'(t), 2'(r));
            end
        end
        wait_quiet();
    endtask

    task automatic stream_one_tile();
        test_name = "single_stream";
        cfg_write(2'd2, CFG_REG_START, cfg_data_t'($random(seed) & 63));
        cfg_write(2'd2, CFG_REG_COUNT, 32'd5);
        start_streams(4'b0100);
        cfg_read(2'd2, CFG_REG_STATUS);
        cfg_read(2'd0, CFG_REG_STATUS);
        wait_quiet();
    endtask

    // tile 0 has an empty range
    task automatic stream_two_tiles();
        test_name = "dual_stream";
        cfg_write(2'd0, CFG_REG_START, cfg_data_t'($random(seed) & 63));
        cfg_write(2'd0, CFG_REG_COUNT, 32'd0);
        cfg_write(2'd1, CFG_REG_START, cfg_data_t'($random(seed) & 63));
        cfg_write(2'd1, CFG_REG_COUNT, 32'd3);
        cfg_write(2'd3, CFG_REG_START, cfg_data_t'($random(seed) & 63));
        cfg_write(2'd3, CFG_REG_COUNT, 32'd4);
        start_streams(4'b1011);
        wait_quiet();
    endtask

    initial begin
        seed      = 42633;
        test_name = "reset";
        // config registers come out of reset as zero
        for (int t = 0; t < NUM_GLB_TILES; t++) begin
            model_start[t] = '0;
            model_count[t] = '0;
            strm_first[t]  = 0;
            strm_last[t]   = -2;
        end
        rst          = 1'b1;
        proc_wr_strb = '0;
        proc_wr_addr = '0;
        proc_wr_data = '0;
        proc_rd_addr = '0;
        cfg_wr_addr  = '0;
        cfg_wr_data  = '0;
        cfg_rd_addr  = '0;
        drive_idle();
        repeat (10) @(negedge clk);
        rst = 1'b0;
        read_reset_values();
        write_then_read();
        merge_partial_strobes();
        read_back_cfg_regs();
        stream_one_tile();
        stream_two_tiles();
        failures = failures + global_buffer_inst.global_buffer_props_inst.fail_count;
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // about 450 host operations over all tests at 200 cycles each
    initial begin
        repeat (450 * 200) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", 450 * 200);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
